//--- source/game_params.svh
// Build-time configuration of the memory game
// Sequence ROM depth, level-0 game length and the play timeout

`ifndef GAME_PARAMS_SVH
`define GAME_PARAMS_SVH

// Entries in the sequence ROM, one per round of a level-1 game
`define GAME_ROM_DEPTH 16

// Rounds in a level-0 game
`define GAME_HALF_DEPTH 8

// Clock cycles allowed between two plays
// At 50 MHz this is 100 us
`define GAME_TIMEOUT_CYCLES 5000

`endif

//--- source/game_data_pkg.sv
// Data types shared by the memory game datapath
// Play, sequence address and wait counter widths
// Fixed play sequence read by the ROM

`include "game_params.svh"

package game_data_pkg;

    // One play, a one-hot key mask
    typedef logic [3:0] play_t;

    // Index into the sequence ROM
    typedef logic [3:0] seq_addr_t;

    // Timeout counter, wide enough for GAME_TIMEOUT_CYCLES
    typedef logic [12:0] wait_count_t;

    // Sequence to be repeated, as key masks
    localparam play_t GAME_SEQUENCE [0:`GAME_ROM_DEPTH-1] = '{
        4'h1, 4'h2, 4'h4, 4'h8,
        4'h4, 4'h2, 4'h1, 4'h8,
        4'h2, 4'h4, 4'h1, 4'h8,
        4'h8, 4'h1, 4'h4, 4'h2
    };

endpackage

//--- source/game_ctrl_pkg.sv
// Control types of the memory game
// Controller state enum
// Control bundle to the datapath and status bundle to the outside

package game_ctrl_pkg;

    import game_data_pkg::*;

    // Controller states
    typedef enum logic [2:0] {
        st_idle,
        st_wait_play,
        st_compare,
        st_next,
        st_won,
        st_lost
    } game_state_e;

    // Commands from the controller to capture and store
    typedef struct packed {
        // Empty the play register
        logic clear_play;
        // Back to round 0, restart the timer, load the level
        logic clear_addr;
        // Step to the next sequence entry
        logic advance_addr;
        // Timer runs only while this is set
        logic arm_timer;
    } game_ctrl_t;

    // Game status seen by the player
    typedef struct packed {
        // Waiting for a play
        logic      ready;
        logic      won;
        logic      lost;
        // Loss came from the timer, not a wrong key
        logic      timed_out;
        // Current sequence index
        seq_addr_t round;
    } game_status_t;

endpackage

//--- source/play_capture.sv
// Play capture for the memory game
// Key sampling and press detection
// Play register loaded on each new press
// Wait timer that flags a missing play

`timescale 1ns/1ns

`include "game_params.svh"

module play_capture
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  play_t      keys,
    input  game_ctrl_t ctrl,
    output logic       play_strobe,
    output play_t      play,
    output logic       timeout
);

    // Keys as sampled on the first edge
    play_t       keys_q;
    // Any key held one cycle later
    logic        pressed_q;
    // Keys went from all released to something pressed
    logic        new_press;
    wait_count_t wait_count;

    // Register the raw keys
    always_ff @(posedge clock) begin
        if (reset) begin
            keys_q    <= '0;
            pressed_q <= 1'b0;
        end else begin
            keys_q    <= keys;
            pressed_q <= |keys_q;
        end
    end

    // Rising edge of "any key pressed"
    // Holding a key never gives a second press
    assign new_press = (|keys_q) && !pressed_q;

    // Strobe lines up with the loaded play
    always_ff @(posedge clock) begin
        if (reset) begin
            play_strobe <= 1'b0;
        end else begin
            play_strobe <= new_press;
        end
    end

    // Play register, emptied at game start
    always_ff @(posedge clock) begin
        if (ctrl.clear_play) begin
            play <= '0;
        end else if (new_press) begin
            play <= keys_q;
        end
    end

    // Wait timer
    // Restarts on each play and on game start
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_addr || play_strobe) begin
            wait_count <= '0;
        end else if (ctrl.arm_timer) begin
            wait_count <= wait_count + 1'b1;
        end
    end

    // One cycle at the limit
    assign timeout = ctrl.arm_timer &&
                     (wait_count == wait_count_t'(`GAME_TIMEOUT_CYCLES - 1));

endmodule

//--- source/sequence_store.sv
// Sequence storage for the memory game
// Level register captured at game start
// Address counter over the sequence
// Synchronous ROM and end-of-round flag

`timescale 1ns/1ns

`include "game_params.svh"

module sequence_store
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       level,
    input  game_ctrl_t ctrl,
    output play_t      expected,
    output logic       last_entry,
    output seq_addr_t  round
);

    // Level chosen at start, 0 short game, 1 full game
    logic      level_q;
    seq_addr_t addr;
    // Final index of the chosen level
    seq_addr_t last_addr;

    // Level is sampled only when a game starts
    always_ff @(posedge clock) begin
        if (reset) begin
            level_q <= 1'b0;
        end else if (ctrl.clear_addr) begin
            level_q <= level;
        end
    end

    // Address counter
    // Clear wins over advance
    always_ff @(posedge clock) begin
        if (reset || ctrl.clear_addr) begin
            addr <= '0;
        end else if (ctrl.advance_addr) begin
            addr <= addr + 1'b1;
        end
    end

    // Clocked ROM read
    // Valid one cycle after the address moves
    always_ff @(posedge clock) begin
        expected <= GAME_SEQUENCE[addr];
    end

    // Index 7 for level 0, index 15 for level 1
    assign last_addr = level_q ? seq_addr_t'(`GAME_ROM_DEPTH - 1)
                               : seq_addr_t'(`GAME_HALF_DEPTH - 1);

    assign last_entry = (addr == last_addr);

    // Round shown to the player
    assign round = addr;

endmodule

//--- source/game_controller.sv
// Control unit of the memory game
// FSM over wait, compare and next
// Win and loss decision, timeout tracking
// Control bundle and status bundle

`timescale 1ns/1ns

module game_controller
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  logic         play_strobe,
    input  play_t        play,
    input  logic         timeout,
    input  play_t        expected,
    input  logic         last_entry,
    input  seq_addr_t    round,
    output game_ctrl_t   ctrl,
    output game_status_t status
);

    game_state_e state;
    game_state_e state_next;
    // Start accepted, only when no game is running
    logic        restart;
    // Loss caused by the timer, held with the result
    logic        timed_out_q;
    logic        match;

    // Start is ignored mid-game
    assign restart = start &&
                     ((state == st_idle) || (state == st_won) || (state == st_lost));

    // Plain equality, play against the ROM entry
    assign match = (play == expected);

    // State register
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Next state
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (restart) begin
                    state_next = st_wait_play;
                end
            end
            st_wait_play: begin
                // A play beats a timeout in the same cycle
                if (play_strobe) begin
                    state_next = st_compare;
                end else if (timeout) begin
                    state_next = st_lost;
                end
            end
            st_compare: begin
                if (!match) begin
                    state_next = st_lost;
                end else if (last_entry) begin
                    state_next = st_won;
                end else begin
                    state_next = st_next;
                end
            end
            st_next: begin
                state_next = st_wait_play;
            end
            st_won, st_lost: begin
                // Result held until a new start
                if (restart) begin
                    state_next = st_wait_play;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Timeout flag
    // Set on the edge that leaves wait_play for lost
    always_ff @(posedge clock) begin
        if (reset || restart) begin
            timed_out_q <= 1'b0;
        end else if ((state == st_wait_play) && !play_strobe && timeout) begin
            timed_out_q <= 1'b1;
        end
    end

    // Commands to the datapath
    // Start clears play, address, timer and loads the level in one edge
    always_comb begin
        ctrl.clear_play   = restart;
        ctrl.clear_addr   = restart;
        ctrl.advance_addr = (state == st_next);
        ctrl.arm_timer    = (state == st_wait_play);
    end

    // Status decoded from the state
    always_comb begin
        status.ready     = (state == st_wait_play);
        status.won       = (state == st_won);
        status.lost      = (state == st_lost);
        status.timed_out = timed_out_q;
        status.round     = round;
    end

endmodule

//--- source/memory_game.sv
// Top level of the memory game
// Play capture and sequence store side by side
// Controller combines their results

`timescale 1ns/1ns

module memory_game
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         start,
    input  logic         level,
    input  play_t        keys,
    output game_status_t status
);

    // Controller commands, shared by both datapath blocks
    game_ctrl_t ctrl;

    // From capture
    logic       play_strobe;
    play_t      play;
    logic       timeout;

    // From store
    play_t      expected;
    logic       last_entry;
    seq_addr_t  round;

    play_capture i_capture (
        .clock       (clock),
        .reset       (reset),
        .keys        (keys),
        .ctrl        (ctrl),
        .play_strobe (play_strobe),
        .play        (play),
        .timeout     (timeout)
    );

    sequence_store i_store (
        .clock      (clock),
        .reset      (reset),
        .level      (level),
        .ctrl       (ctrl),
        .expected   (expected),
        .last_entry (last_entry),
        .round      (round)
    );

    game_controller i_control (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .play_strobe (play_strobe),
        .play        (play),
        .timeout     (timeout),
        .expected    (expected),
        .last_entry  (last_entry),
        .round       (round),
        .ctrl        (ctrl),
        .status      (status)
    );

endmodule

//--- testbench/memory_game_properties.sv
// Concurrent assertions on the memory game controller
// Exclusive results, result hold, strobe width, state after reset

`timescale 1ns/1ns

module memory_game_properties
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
(
    input logic         clock,
    input logic         reset,
    input logic         start,
    input logic         play_strobe,
    input game_status_t status
);

    // Failed assertions so far, read by the testbench
    int unsigned failures = 0;

    // A game ends one way only
    // A win never carries the loss or timer flag
    a_one_result: assert property (@(posedge clock) disable iff (reset)
        !(status.won && (status.lost || status.timed_out)))
    else begin
        failures = failures + 1;
        $error("won is set together with a loss flag");
    end

    // Results held until a new start
    a_won_holds: assert property (@(posedge clock) disable iff (reset)
        (status.won && !start) |=> status.won)
    else begin
        failures = failures + 1;
        $error("won dropped without a start");
    end

    a_lost_holds: assert property (@(posedge clock) disable iff (reset)
        (status.lost && !start) |=> status.lost)
    else begin
        failures = failures + 1;
        $error("lost dropped without a start");
    end

    // One pulse per press
    a_strobe_width: assert property (@(posedge clock) disable iff (reset)
        play_strobe |=> !play_strobe)
    else begin
        failures = failures + 1;
        $error("play_strobe lasted more than one cycle");
    end

    // Idle after reset
    a_ready_after_reset: assert property (@(posedge clock)
        reset |=> !status.ready)
    else begin
        failures = failures + 1;
        $error("ready is set right after reset");
    end

endmodule

//--- testbench/tb_memory_game.sv
// Testbench for the memory game
// Clock, reset, start strobe and key stimulus
// Directed tests for wins, losses and restart
// Value check, bounded waits, watchdog and verdict

`timescale 1ns/1ns

`include "game_params.svh"

module tb_memory_game
    import game_data_pkg::*;
    import game_ctrl_pkg::*;
();

    // Longest wait for one play to be taken and decided
    localparam int PLAY_WAIT_CYCLES = 20;
    // Games played over the whole run, with margin
    localparam int GAMES = 6;
    // Three timeout waits plus 400 cycles per game, at 20 ns per cycle
    localparam longint WATCHDOG_NS = (3 * `GAME_TIMEOUT_CYCLES + 400 * GAMES) * 20;

    logic         clock;
    logic         reset;
    logic         start;
    logic         level;
    play_t        keys;
    game_status_t status;

    // Random stream for the mismatch test
    integer       seed = 32'h7c77;

    memory_game i_dut (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .level  (level),
        .keys   (keys),
        .status (status)
    );

    // Controller properties
    bind game_controller memory_game_properties i_props (
        .clock       (clock),
        .reset       (reset),
        .start       (start),
        .play_strobe (play_strobe),
        .status      (status)
    );

    // 20 ns clock
    always #10 clock = ~clock;

    // Ends the run with a plain reason
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                               $time, name, actual, expected));
        end
    endtask

    // Whole status bundle at once
    task automatic check_status(input logic exp_ready, input logic exp_won,
                                input logic exp_lost, input logic exp_timed_out,
                                input int exp_round);
        check_value("status.ready", status.ready, exp_ready);
        check_value("status.won", status.won, exp_won);
        check_value("status.lost", status.lost, exp_lost);
        check_value("status.timed_out", status.timed_out, exp_timed_out);
        check_value("status.round", status.round, exp_round);
    endtask

    // Single-cycle start strobe with the level beside it
    task automatic start_game(input logic game_level);
        @(negedge clock);
        start = 1'b1;
        level = game_level;
        @(negedge clock);
        start = 1'b0;
        // Fresh game, round 0, nothing decided
        check_status(1'b1, 1'b0, 1'b0, 1'b0, 0);
    endtask

    // Key mask held for two cycles, then released
    task automatic press_keys(input play_t mask);
        @(negedge clock);
        keys = mask;
        repeat (2) @(negedge clock);
        keys = '0;
    endtask

    // Ready drops once the play is taken, then ready, won or lost follows
    task automatic wait_for_result();
        int cycles;
        cycles = 0;
        while (status.ready) begin
            @(negedge clock);
            cycles++;
            if (cycles > PLAY_WAIT_CYCLES) begin
                fail_run("The controller did not take the play in time");
            end
        end
        cycles = 0;
        while (!(status.ready || status.won || status.lost)) begin
            @(negedge clock);
            cycles++;
            if (cycles > PLAY_WAIT_CYCLES) begin
                fail_run("The controller reached no decision on the play in time");
            end
        end
    endtask

    // One correct play at index idx of a game ending at final_idx
    task automatic play_correct(input int idx, input int final_idx);
        press_keys(GAME_SEQUENCE[idx]);
        wait_for_result();
        if (idx == final_idx) begin
            check_status(1'b0, 1'b1, 1'b0, 1'b0, idx);
        end else begin
            check_status(1'b1, 1'b0, 1'b0, 1'b0, idx + 1);
        end
    endtask

    // Nonzero mask other than the expected one
    task automatic pick_wrong_mask(input play_t expected, output play_t mask);
        mask = play_t'($random(seed));
        while ((mask == '0) || (mask == expected)) begin
            mask = play_t'($random(seed));
        end
    endtask

    task automatic test_reset_state();
        check_status(1'b0, 1'b0, 1'b0, 1'b0, 0);
    endtask

    task automatic test_level0_win();
        start_game(1'b0);
        for (int i = 0; i < `GAME_HALF_DEPTH; i++) begin
            play_correct(i, `GAME_HALF_DEPTH - 1);
        end
        // Keys after the win are ignored
        press_keys(GAME_SEQUENCE[0]);
        repeat (6) @(negedge clock);
        check_status(1'b0, 1'b1, 1'b0, 1'b0, `GAME_HALF_DEPTH - 1);
    endtask

    // Play 8 must not win at level 1
    task automatic test_level1_win();
        start_game(1'b1);
        for (int i = 0; i < `GAME_ROM_DEPTH; i++) begin
            play_correct(i, `GAME_ROM_DEPTH - 1);
        end
    endtask

    task automatic test_mismatch();
        int    fail_idx;
        play_t wrong;
        fail_idx = $unsigned($random(seed)) % `GAME_HALF_DEPTH;
        start_game(1'b0);
        for (int i = 0; i < fail_idx; i++) begin
            play_correct(i, `GAME_HALF_DEPTH - 1);
        end
        pick_wrong_mask(GAME_SEQUENCE[fail_idx], wrong);
        press_keys(wrong);
        wait_for_result();
        check_status(1'b0, 1'b0, 1'b1, 1'b0, fail_idx);
    endtask

    // Two plays, then no more keys
    task automatic test_timeout();
        int waited;
        start_game(1'b0);
        play_correct(0, `GAME_HALF_DEPTH - 1);
        play_correct(1, `GAME_HALF_DEPTH - 1);
        waited = 0;
        while (!status.lost && (waited < `GAME_TIMEOUT_CYCLES + 20)) begin
            @(negedge clock);
            waited++;
            if ((status.lost || status.timed_out) &&
                (waited < `GAME_TIMEOUT_CYCLES - 10)) begin
                fail_run($sformatf("The game timed out after only %0d cycles", waited));
            end
        end
        if (!status.lost) begin
            fail_run("The game did not time out after the wait limit");
        end
        check_status(1'b0, 1'b0, 1'b1, 1'b1, 2);
    endtask

    // Start after the loss, result and round cleared in start_game
    task automatic test_restart();
        start_game(1'b0);
        for (int i = 0; i < `GAME_HALF_DEPTH; i++) begin
            play_correct(i, `GAME_HALF_DEPTH - 1);
        end
    endtask

    // Hung run
    initial begin
        #(WATCHDOG_NS);
        fail_run("The watchdog expired before the tests finished");
    end

    // Bound assertion failures end the run early
    always @(negedge clock) begin
        if (i_dut.i_control.i_props.failures != 0) begin
            fail_run("A controller assertion failed");
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        level = 1'b0;
        keys  = '0;
        repeat (8) @(negedge clock);
        reset = 1'b0;

        test_reset_state();
        test_level0_win();
        test_level1_win();
        test_mismatch();
        test_timeout();
        test_restart();

        @(negedge clock);
        if (i_dut.i_control.i_props.failures != 0) begin
            fail_run("A controller assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

//--- memory_game.f
+incdir+source
source/game_data_pkg.sv
source/game_ctrl_pkg.sv
source/play_capture.sv
source/sequence_store.sv
source/game_controller.sv
source/memory_game.sv
testbench/memory_game_properties.sv
testbench/tb_memory_game.sv

//--- Bender.yml
package:
  name: memory_game

sources:
  - include_dirs:
      - source
    files:
      - source/game_data_pkg.sv
      - source/game_ctrl_pkg.sv
      - source/play_capture.sv
      - source/sequence_store.sv
      - source/game_controller.sv
      - source/memory_game.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/memory_game_properties.sv
      - testbench/tb_memory_game.sv
